// File: aBufIn.sv
module aBufIn #(
    parameter int DEPTH = 1024  // samples per frame, a multiple of 8
) (
    input  logic           clk,
    input  logic           rst,
    input  accelPkg::beatT hostData,
    input  logic           hostValid,
    output logic           inReady,
    bufCtrlIf.buffer       ctl,
    sampleIf.source        smp
);

    localparam int SPB = accelPkg::SAMPLES_PER_BEAT;
    localparam int BEATS = DEPTH / SPB;                         // beats per frame
    localparam int BEAT_AW = (BEATS > 1) ? $clog2(BEATS) : 1;
    localparam int LANE_BITS = $clog2(SPB);                     // sample slot inside a beat
    localparam int SMP_W = $bits(accelPkg::sampleT);
    localparam int PART_W = $bits(accelPkg::partT);

    accelPkg::beatT mem [BEATS];                // whole beats as the host wrote them
    logic [BEAT_AW-1:0] wrIdx;                  // next beat slot to fill
    logic [BEAT_AW+LANE_BITS-1:0] rdIdx;        // read pointer as {beat, lane}
    logic [BEAT_AW-1:0] rdBeat;
    logic [LANE_BITS-1:0] rdLane;
    accelPkg::beatT curBeat;
    accelPkg::sampleT curSmp;
    logic wrEn;

    // the host may only write while a frame slot is free, anything else is lost
    assign inReady = ~ctl.full;
    assign wrEn = hostValid & inReady;

    // split the read pointer into the beat and the lane within that beat
    assign rdBeat = rdIdx[BEAT_AW+LANE_BITS-1:LANE_BITS];
    assign rdLane = rdIdx[LANE_BITS-1:0];
    assign curBeat = mem[rdBeat];
    assign curSmp = curBeat[rdLane*SMP_W +: SMP_W];   // sample 0 is in the lowest bits

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrIdx] <= hostData;
        end
    end

    // write index and the full level
    // full rises on the edge that stores the final beat of the frame
    always_ff @(posedge clk) begin
        if (rst || ctl.bufRelease) begin
            wrIdx <= '0;
            ctl.full <= 1'b0;
        end else if (wrEn) begin
            wrIdx <= wrIdx + 1'b1;
            ctl.full <= (wrIdx == BEAT_AW'(BEATS - 1));  // this write completes the frame
        end
    end

    always_ff @(posedge clk) begin
        if (rst || ctl.bufRelease) begin
            rdIdx <= '0;                    // next sweep starts at sample 0 again
        end else if (ctl.rdEn) begin
            rdIdx <= rdIdx + 1'b1;
        end
    end

    // sample leaves one cycle after its read strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            smp.valid <= 1'b0;
            smp.last <= 1'b0;
        end else begin
            smp.valid <= ctl.rdEn;
            smp.last <= ctl.rdEn & ctl.rdLast;
        end
    end

    always_ff @(posedge clk) begin
        if (ctl.rdEn) begin
            smp.re <= curSmp[PART_W-1:0];       // real part is the low half
            smp.im <= curSmp[SMP_W-1:PART_W];
        end
    end

endmodule

// File: aBufOut.sv
module aBufOut #(
    parameter int DEPTH = 1024  // samples per frame, a multiple of 8
) (
    input  logic           clk,
    input  logic           rst,
    sampleIf.sink          smp,
    output accelPkg::beatT dataOut,
    output logic           dataOutValid
);

    localparam int SPB = accelPkg::SAMPLES_PER_BEAT;
    localparam int BEATS = DEPTH / SPB;                         // beats per drained frame
    localparam int AW = $clog2(DEPTH);
    localparam int BEAT_AW = (BEATS > 1) ? $clog2(BEATS) : 1;
    localparam int SMP_W = $bits(accelPkg::sampleT);

    // one result per slot, kept as {imag, real}
    accelPkg::sampleT mem [DEPTH];
    logic [AW-1:0] wrIdx;       // slot for the next incoming result
    logic [BEAT_AW-1:0] drCnt;  // beat number being drained
    logic draining;             // a finished frame is going out
    logic [AW-1:0] drBase;      // first sample of the current drain beat

    assign drBase = AW'(drCnt * SPB);

    always_ff @(posedge clk) begin
        if (smp.valid) begin
            mem[wrIdx] <= {smp.im, smp.re};
        end
    end

    // the last sample puts the index back to 0, so each frame starts at slot 0
    always_ff @(posedge clk) begin
        if (rst) begin
            wrIdx <= '0;
        end else if (smp.valid) begin
            wrIdx <= smp.last ? '0 : wrIdx + 1'b1;
        end
    end

    // drain sequencer, runs for BEATS cycles after the frame's last write
    // the next frame's first write is many cycles away, well after the drain ends
    always_ff @(posedge clk) begin
        if (rst) begin
            draining <= 1'b0;
            drCnt <= '0;
        end else if (smp.valid && smp.last) begin
            draining <= 1'b1;
            drCnt <= '0;
        end else if (draining) begin
            drCnt <= drCnt + 1'b1;
            if (drCnt == BEAT_AW'(BEATS - 1)) begin
                draining <= 1'b0;           // final beat goes out this cycle
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dataOutValid <= 1'b0;
        end else begin
            dataOutValid <= draining;
        end
    end

    // gather eight neighbouring results into one beat, lowest sample in the lowest bits
    always_ff @(posedge clk) begin
        if (draining) begin
            for (int i = 0; i < SPB; i++) begin
                dataOut[i*SMP_W +: SMP_W] <= mem[drBase + AW'(i)];
            end
        end
    end

endmodule

// File: accelCtrl.sv
module accelCtrl #(
    parameter int DEPTH = 1024  // samples per frame, also the length of the read sweep
) (
    input  logic           clk,
    input  logic           rst,
    input  accelPkg::coefT coefRe,
    input  accelPkg::coefT coefIm,
    bufCtrlIf.ctrl         ctl,
    output accelPkg::coefT gainRe,
    output accelPkg::coefT gainIm,
    output logic           busy
);

    localparam int CNT_W = $clog2(DEPTH);

    accelPkg::ctrlStateT state;
    logic [CNT_W-1:0] rdCnt;    // reads issued so far in this sweep
    logic sweepDone;            // the read this cycle is number DEPTH
    logic frameStart;           // leaving IDLE this cycle

    assign sweepDone = (rdCnt == CNT_W'(DEPTH - 1));

    // full is still high during the release pulse, so that cycle must not
    // start the same frame a second time
    assign frameStart = (state == accelPkg::IDLE) && ctl.full && !ctl.bufRelease;

    // every RUN cycle is one read
    assign ctl.rdEn = (state == accelPkg::RUN);
    assign ctl.rdLast = ctl.rdEn & sweepDone;

    // release belongs to the frame, so it still counts as busy
    assign busy = ctl.rdEn | ctl.bufRelease;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= accelPkg::IDLE;
            rdCnt <= '0;
            ctl.bufRelease <= 1'b0;
        end else begin
            ctl.bufRelease <= 1'b0;                 // a pulse unless set below
            case (state)
                accelPkg::IDLE: begin
                    rdCnt <= '0;
                    if (frameStart) begin
                        state <= accelPkg::RUN;
                    end
                end
                accelPkg::RUN: begin
                    rdCnt <= rdCnt + 1'b1;
                    if (sweepDone) begin
                        // last read went out, free the buffer on the next cycle
                        state <= accelPkg::IDLE;
                        ctl.bufRelease <= 1'b1;
                    end
                end
                default: begin
                    state <= accelPkg::IDLE;
                end
            endcase
        end
    end

    // the gain pair is sampled once per frame and held for the whole sweep,
    // so a change on the inputs mid-frame only affects the next frame
    always_ff @(posedge clk) begin
        if (frameStart) begin
            gainRe <= coefRe;
            gainIm <= coefIm;
        end
    end

endmodule

// File: accelPkg.sv
package accelPkg;

    // one real or imaginary component, two's complement
    typedef logic signed [31:0] partT;

    // one complex sample, imaginary part in [63:32] and real part in [31:0]
    typedef logic [63:0] sampleT;

    // one host memory beat, sample 0 sits in the lowest 64 bits
    typedef logic [511:0] beatT;

    // gain component in Q1.15, 32767 is the closest value to one
    typedef logic signed [15:0] coefT;

    // eight 64-bit samples fill one 512-bit beat
    localparam int SAMPLES_PER_BEAT = 8;

    // fractional bits of the coefficient, removed again after each multiply
    localparam int FRAC_BITS = 15;

    // frame sequencer states
    // the cycle that frees the input buffer is a pulse on the way out of RUN,
    // so it needs no state of its own
    typedef enum logic {
        IDLE,   // waiting for the input buffer to report a whole frame
        RUN     // read sweep in progress, one sample per cycle
    } ctrlStateT;

endpackage

// File: accelTb.sv
module accelTb;

    localparam int DEPTH = 64;                              // 8 beats per frame
    localparam int SPB = accelPkg::SAMPLES_PER_BEAT;
    localparam int BEATS = DEPTH / SPB;
    localparam int NROWS = 5;
    localparam int TIMEOUT = 2000;                          // cycles allowed for any single wait

    typedef enum int {
        RAND_SMP,       // samples from the LCG
        FIXED_SMP,      // a ramp that depends on the sample index
        EXTREME_SMP     // largest positive and negative parts
    } modeT;

    logic clk;
    logic rst;
    accelPkg::beatT hostData;
    logic hostValid;
    accelPkg::coefT coefRe;
    accelPkg::coefT coefIm;
    logic inReady;
    accelPkg::beatT dataOut;
    logic dataOutValid;
    logic busy;

    // one row per frame, the idle flag asks for a full drain and an idle check afterwards
    // rows 2 to 4 run back to back so each loads while the one before drains
    string nameTbl[NROWS] = '{"unity", "quarterTurn", "extreme", "b2bFixed", "b2bRandom"};
    int coefReTbl[NROWS] = '{32767, 0, -32768, 12345, -32768};
    int coefImTbl[NROWS] = '{0, 32767, 32767, -20000, 5};
    modeT modeTbl[NROWS] = '{RAND_SMP, RAND_SMP, EXTREME_SMP, FIXED_SMP, RAND_SMP};
    bit idleTbl[NROWS] = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b1};

    accelPkg::beatT expQ[$];    // expected output beats in order
    int rowQ[$];                // table row of each expected beat
    int idxQ[$];                // beat number inside its frame
    accelPkg::beatT expHead;
    int rowHead;
    int idxHead;
    int checkErrs = 0;
    int otherErrs = 0;
    logic [31:0] lcgState = 32'd22;

    accelTop #(
        .DEPTH(DEPTH)
    ) DUT (
        .clk(clk),
        .rst(rst),
        .hostData(hostData),
        .hostValid(hostValid),
        .coefRe(coefRe),
        .coefIm(coefIm),
        .inReady(inReady),
        .dataOut(dataOut),
        .dataOutValid(dataOutValid),
        .busy(busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    // upper halves of two draws per part, the low bits of an LCG repeat too soon
    function automatic accelPkg::sampleT makeSample(modeT mode, int idx);
        logic [31:0] re;
        logic [31:0] im;
        logic [31:0] a;
        logic [31:0] b;
        case (mode)
            RAND_SMP: begin
                a = lcgNext();
                b = lcgNext();
                re = {a[31:16], b[31:16]};
                a = lcgNext();
                b = lcgNext();
                im = {a[31:16], b[31:16]};
            end
            FIXED_SMP: begin
                re = 32'(idx * 65536 - 1000000);
                im = 32'(7 - idx * 3001);
            end
            default: begin
                re = idx[0] ? 32'h8000_0000 : 32'h7fff_ffff;
                im = idx[1] ? 32'h8000_0000 : 32'h7fff_ffff;
            end
        endcase
        return {im, re};
    endfunction

    // complex multiply in wide signed arithmetic, then shift out the Q1.15 fraction
    function automatic accelPkg::sampleT applyGain(accelPkg::sampleT s, accelPkg::coefT gr,
                                                   accelPkg::coefT gi);
        longint re;
        longint im;
        longint outRe;
        longint outIm;
        re = longint'($signed(s[31:0]));
        im = longint'($signed(s[63:32]));
        outRe = (re * longint'(gr) - im * longint'(gi)) >>> accelPkg::FRAC_BITS;
        outIm = (re * longint'(gi) + im * longint'(gr)) >>> accelPkg::FRAC_BITS;
        return {outIm[31:0], outRe[31:0]};  // only the low 32 bits of each part survive
    endfunction

    task automatic endRun();
        $display("errors: %0d value mismatches, %0d other failures", checkErrs, otherErrs);
        if (checkErrs == 0 && otherErrs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    task automatic waitReady();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!inReady && n < TIMEOUT);
        if (!inReady) begin
            otherErrs++;
            $display("ERROR: timed out waiting for the input buffer to accept beats");
            endRun();
        end
    endtask

    task automatic waitBlocked();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (inReady && n < TIMEOUT);
        if (inReady) begin
            otherErrs++;
            $display("ERROR: input buffer never reported full after a whole frame");
            endRun();
        end
    endtask

    task automatic waitDrain(int r);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (expQ.size() != 0 && n < TIMEOUT);
        if (expQ.size() != 0) begin
            otherErrs++;
            $display("ERROR: %s output drain never finished, %0d beats missing",
                     nameTbl[r], expQ.size());
            endRun();
        end
    endtask

    // values read just after the edge are the settled ones from the cycle before
    task automatic checkIdle(string where);
        @(posedge clk);
        assert (dataOutValid === 1'b0) else begin
            checkErrs++;
            $display("CHECK FAILED %s dataOutValid expected 0 actual %b", where, dataOutValid);
        end
        assert (busy === 1'b0) else begin
            checkErrs++;
            $display("CHECK FAILED %s busy expected 0 actual %b", where, busy);
        end
        assert (inReady === 1'b1) else begin
            checkErrs++;
            $display("CHECK FAILED %s inReady expected 1 actual %b", where, inReady);
        end
    endtask

    task automatic loadFrame(int r);
        accelPkg::beatT beat;
        accelPkg::beatT expBeat;
        accelPkg::sampleT s;
        coefRe <= accelPkg::coefT'(coefReTbl[r]);   // latched by the DUT when the frame starts
        coefIm <= accelPkg::coefT'(coefImTbl[r]);
        waitReady();
        for (int b = 0; b < BEATS; b++) begin
            for (int l = 0; l < SPB; l++) begin
                s = makeSample(modeTbl[r], b * SPB + l);
                beat[l*64 +: 64] = s;
                expBeat[l*64 +: 64] = applyGain(s, accelPkg::coefT'(coefReTbl[r]),
                                                accelPkg::coefT'(coefImTbl[r]));
            end
            expQ.push_back(expBeat);
            rowQ.push_back(r);
            idxQ.push_back(b);
            hostData <= beat;
            hostValid <= 1'b1;
            @(posedge clk);     // inReady stays high until our own eighth beat lands
        end
        hostValid <= 1'b0;
        // one junk beat while the buffer is full, it must not reach any frame
        waitBlocked();
        hostData <= {16{32'hdead_beef}};
        hostValid <= 1'b1;
        @(posedge clk);
        hostValid <= 1'b0;
    endtask

    // compares every output beat with the oldest expected one
    always @(posedge clk) begin
        if (dataOutValid === 1'b1) begin
            if (expQ.size() == 0) begin
                otherErrs++;
                $display("ERROR: output beat arrived with no beat expected");
            end else begin
                expHead = expQ.pop_front();
                rowHead = rowQ.pop_front();
                idxHead = idxQ.pop_front();
                assert (dataOut === expHead) else begin
                    checkErrs++;
                    $display("CHECK FAILED %s beat %0d expected %h actual %h",
                             nameTbl[rowHead], idxHead, expHead, dataOut);
                end
            end
        end
    end

    initial begin
        rst = 1'b1;
        hostValid = 1'b0;
        hostData = '0;
        coefRe = '0;
        coefIm = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        checkIdle("reset");
        for (int r = 0; r < NROWS; r++) begin
            loadFrame(r);
            if (idleTbl[r]) begin
                waitDrain(r);
                checkIdle(nameTbl[r]);
            end
        end
        endRun();
    end

endmodule

// File: accelTop.sv
module accelTop #(
    parameter int DEPTH = 1024  // samples per frame, a multiple of 8
) (
    input  logic           clk,
    input  logic           rst,
    input  accelPkg::beatT hostData,      // beat from the memory controller
    input  logic           hostValid,
    input  accelPkg::coefT coefRe,        // gain for the next frame, Q1.15
    input  accelPkg::coefT coefIm,
    output logic           inReady,       // low while a whole frame waits in the input buffer
    output accelPkg::beatT dataOut,       // result beat back to the memory controller
    output logic           dataOutValid,
    output logic           busy           // a read sweep or its release is in progress
);

    // gain pair held by the sequencer for the current frame
    accelPkg::coefT gainRe;
    accelPkg::coefT gainIm;

    bufCtrlIf ctl ();       // sequencer to input buffer
    sampleIf inSmp ();      // input buffer to multiplier
    sampleIf mulSmp ();     // multiplier to output buffer

    aBufIn #(
        .DEPTH(DEPTH)
    ) uBufIn (
        .clk(clk),
        .rst(rst),
        .hostData(hostData),
        .hostValid(hostValid),
        .inReady(inReady),
        .ctl(ctl.buffer),
        .smp(inSmp.source)
    );

    accelCtrl #(
        .DEPTH(DEPTH)
    ) uCtrl (
        .clk(clk),
        .rst(rst),
        .coefRe(coefRe),
        .coefIm(coefIm),
        .ctl(ctl.ctrl),
        .gainRe(gainRe),
        .gainIm(gainIm),
        .busy(busy)
    );

    // two-cycle complex gain, keeps the frame marker aligned with the data
    cplxMul uMul (
        .clk(clk),
        .rst(rst),
        .gainRe(gainRe),
        .gainIm(gainIm),
        .inS(inSmp.sink),
        .outS(mulSmp.source)
    );

    aBufOut #(
        .DEPTH(DEPTH)
    ) uBufOut (
        .clk(clk),
        .rst(rst),
        .smp(mulSmp.sink),
        .dataOut(dataOut),
        .dataOutValid(dataOutValid)
    );

endmodule

// File: bufCtrlIf.sv
// control path between the frame sequencer and the input buffer
interface bufCtrlIf;

    logic rdEn;        // read one sample from the buffer this cycle
    logic rdLast;      // the read this cycle is the final one of the sweep
    logic bufRelease;  // one-cycle pulse, the buffer drops its frame and accepts new beats
    logic full;        // level, a whole frame is stored and waiting

    // sequencer side
    modport ctrl (
        output rdEn,
        output rdLast,
        output bufRelease,
        input  full
    );

    // buffer side
    modport buffer (
        input  rdEn,
        input  rdLast,
        input  bufRelease,
        output full
    );

endinterface

// File: cplxMul.sv
module cplxMul (
    input  logic           clk,
    input  logic           rst,
    input  accelPkg::coefT gainRe,
    input  accelPkg::coefT gainIm,
    sampleIf.sink          inS,
    sampleIf.source        outS
);

    // full product width of a 32-bit part times a 16-bit coefficient
    localparam int PROD_W = $bits(accelPkg::partT) + $bits(accelPkg::coefT);

    logic signed [PROD_W-1:0] pReGr;    // re * gRe
    logic signed [PROD_W-1:0] pImGi;    // im * gIm
    logic signed [PROD_W-1:0] pReGi;    // re * gIm
    logic signed [PROD_W-1:0] pImGr;    // im * gRe
    logic signed [PROD_W:0] sumRe;      // one extra bit so the add cannot overflow
    logic signed [PROD_W:0] sumIm;
    logic vPipe;                        // valid after stage one
    logic lPipe;                        // last after stage one

    // stage one, the four partial products
    always_ff @(posedge clk) begin
        if (inS.valid) begin
            pReGr <= inS.re * gainRe;
            pImGi <= inS.im * gainIm;
            pReGi <= inS.re * gainIm;
            pImGr <= inS.im * gainRe;
        end
    end

    assign sumRe = pReGr - pImGi;
    assign sumIm = pReGi + pImGr;

    // stage two, back to Q-format by an arithmetic shift, then keep the low 32 bits
    always_ff @(posedge clk) begin
        if (vPipe) begin
            outS.re <= accelPkg::partT'(sumRe >>> accelPkg::FRAC_BITS);
            outS.im <= accelPkg::partT'(sumIm >>> accelPkg::FRAC_BITS);
        end
    end

    // valid and last follow the data through both stages
    always_ff @(posedge clk) begin
        if (rst) begin
            vPipe <= 1'b0;
            lPipe <= 1'b0;
            outS.valid <= 1'b0;
            outS.last <= 1'b0;
        end else begin
            vPipe <= inS.valid;
            lPipe <= inS.valid & inS.last;
            outS.valid <= vPipe;
            outS.last <= lPipe;
        end
    end

endmodule

// File: project.f
accelPkg.sv
sampleIf.sv
bufCtrlIf.sv
aBufIn.sv
accelCtrl.sv
cplxMul.sv
aBufOut.sv
accelTop.sv
accelTb.sv

// File: sampleIf.sv
// one complex sample per cycle between the datapath stages
interface sampleIf;

    logic           valid;  // one-cycle strobe, one per sample
    accelPkg::partT re;     // real part
    accelPkg::partT im;     // imaginary part
    logic           last;   // marks the final sample of a frame, qualified by valid

    // the stage that produces samples
    modport source (
        output valid,
        output re,
        output im,
        output last
    );

    // the stage that consumes samples
    modport sink (
        input valid,
        input re,
        input im,
        input last
    );

endinterface
